// File: vlog.f
+incdir+hw
hw/cmd_mux_pkg.sv
hw/cmd_window.sv
hw/cmd_buffer.sv
hw/cmd_serializer.sv
hw/cmd_mux.sv
tests/cmd_mux_props.sv
tests/cmd_mux_tb.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module cmd_mux_tb -o Vcmd_mux_tb
	./obj_dir/Vcmd_mux_tb | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing -f vlog.f --top-module cmd_mux_tb

clean:
	rm -rf obj_dir sim.log

// File: tests/cmd_mux_tb.sv
`timescale 1ns/1ps
`include "cmd_mux_params.svh"

module cmd_mux_tb;

    typedef struct packed {
        logic [3:0] test; // behavior number
        logic       seq;  // sequencer source, else bus
        logic       win;  // address inside the control window
        logic [4:0] idx;  // length index
        logic       more; // next entry continues the same burst
    } entry_t;

    localparam int NUM = 20;

    logic rst = 1'b0;
    logic mclk = 1'b1;
    logic start_wburst, wr_en, busy, cseq_wr_en, cseq_ackn, ad_stb;
    cmd_mux_pkg::addr_t pre_waddr, waddr, cseq_waddr, par_waddr;
    cmd_mux_pkg::data_t wdata, cseq_wdata, par_data;
    logic [7:0] byte_ad;

    entry_t tbl [NUM];
    cmd_mux_pkg::addr_t exp_addr [$];
    cmd_mux_pkg::data_t exp_data [$];
    logic               exp_seq  [$];
    int                 exp_cyc  [$]; // accept cycle of a sequencer entry
    logic [15:0] lfsr = 16'd56;
    int errors = 0, cycle = 0, last_stb = -100, last_gap = 1, byte_pos = 6;
    int err_before, n_tests;
    int back_to_back; // strobes right after a single-cycle command
    logic [7:0] exp_bytes [6];
    logic busy_seen;

    cmd_mux DUT (.*);

    always #5 rst = !rst; // 10 ns clock on the rst port

    always @(posedge rst) cycle <= cycle + 1;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[15]};
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]}; // x^16+x^14+x^13+x^11
        end
        return r;
    endfunction

    function automatic int spacing(input cmd_mux_pkg::addr_t a); // cycles to the next strobe
        int idx;
        idx = a[`CMD_LEN_LOW_BIT +: 5];
        if (idx == 0) return 2;
        if (idx == 1 || idx == 6 || idx == 7) return 4;
        if (idx == 2 || idx == 3) return 3;
        if (idx == 13) return 5;
        if (idx == 15) return 1; // single-cycle
        return 6;
    endfunction

    function automatic cmd_mux_pkg::addr_t make_addr(input logic win, input logic [4:0] idx);
        cmd_mux_pkg::addr_t a;
        a = cmd_mux_pkg::addr_t'(rand_bits(6));
        a[`CMD_LEN_LOW_BIT +: 5] = idx;
        if (!win) a[12] = 1'b1; // lands outside the masked window
        return a;
    endfunction

    // output monitor, sampled mid-cycle where outputs are stable
    always @(negedge rst) begin
        logic               have;
        cmd_mux_pkg::addr_t ea;
        cmd_mux_pkg::data_t ed;
        int                 gap;
        if (!mclk) begin
            if (busy) busy_seen = 1'b1;
            if (ad_stb) begin
                gap = cycle - last_stb;
                assert (gap >= last_gap)
                    else begin
                        $display("strobe %0d cycles after the previous one, %0d needed",
                                 gap, last_gap);
                        errors++;
                    end
                if (last_gap == 1 && gap == 1) begin
                    back_to_back++;
                end
                last_stb = cycle;
                have = exp_addr.size() != 0;
                ea = '0;
                ed = '0;
                if (!have) begin
                    $display("unexpected strobe for address 0x%h", par_waddr);
                    errors++;
                end else if (exp_seq[0] && exp_addr.size() > 1 && !exp_seq[1]
                             && cycle == exp_cyc[0] + 1
                             && par_waddr == exp_addr[1] && par_data == exp_data[1]) begin
                    // bus word popped in the same cycle the sequencer was accepted
                    ea = exp_addr[1];
                    ed = exp_data[1];
                    exp_addr.delete(1);
                    exp_data.delete(1);
                    exp_seq.delete(1);
                    exp_cyc.delete(1);
                end else begin
                    ea = exp_addr.pop_front();
                    ed = exp_data.pop_front();
                    void'(exp_seq.pop_front());
                    void'(exp_cyc.pop_front());
                end
                if (have) begin
                    assert (par_waddr == ea)
                        else begin
                            $display("MISMATCH par_waddr exp 0x%h got 0x%h", ea, par_waddr);
                            errors++;
                        end
                    assert (par_data == ed)
                        else begin
                            $display("MISMATCH par_data exp 0x%h got 0x%h", ed, par_data);
                            errors++;
                        end
                end
                last_gap = spacing(ea);
                exp_bytes = '{ea[7:0], 8'(ea >> 8), ed[7:0], ed[15:8], ed[23:16], ed[31:24]};
                byte_pos = 0;
            end else if (byte_pos < 6) begin
                byte_pos++;
            end
            assert (byte_ad == (byte_pos < 6 ? exp_bytes[byte_pos] : 8'h00))
                else begin
                    $display("MISMATCH byte_ad exp 0x%h got 0x%h at byte %0d",
                             byte_pos < 6 ? exp_bytes[byte_pos] : 8'h00, byte_ad, byte_pos);
                    errors++;
                end
        end
    end

    task automatic announce(input cmd_mux_pkg::addr_t a);
        int t;
        start_wburst <= 1'b1;
        pre_waddr    <= a;
        for (t = 0; t < 200; t++) begin
            @(negedge rst);
            if (!busy) break;
        end
        if (t == 200) begin
            $display("timeout: busy never fell before a burst");
            errors++;
        end
        @(posedge rst);
        start_wburst <= 1'b0;
    endtask

    task automatic offer_seq(input cmd_mux_pkg::addr_t a, input cmd_mux_pkg::data_t d);
        int t;
        int pos;
        int acc; // cycle of cseq_ackn
        cseq_wr_en <= 1'b1;
        cseq_waddr <= a;
        cseq_wdata <= d;
        for (t = 0; t < 200; t++) begin
            @(negedge rst);
            if (cseq_ackn) break;
        end
        acc = cycle;
        @(posedge rst);
        cseq_wr_en <= 1'b0;
        if (t == 200) begin
            $display("timeout: sequencer command never accepted");
            errors++;
        end else begin
            pos = 0;
            while (pos < exp_seq.size() && exp_seq[pos]) pos++; // ahead of waiting bus words
            exp_addr.insert(pos, a);
            exp_data.insert(pos, d);
            exp_seq.insert(pos, 1'b1);
            exp_cyc.insert(pos, acc);
        end
    endtask

    task automatic drain;
        int t;
        for (t = 0; t < 300 && exp_addr.size() != 0; t++) @(negedge rst);
        if (exp_addr.size() != 0) begin
            $display("timeout: %0d commands never appeared", exp_addr.size());
            errors++;
        end
        repeat (12) @(posedge rst); // catch strays
    endtask

    initial begin
        cmd_mux_pkg::addr_t a;
        cmd_mux_pkg::data_t d;
        tbl = '{'{2,0,1,0,0},  '{3,0,0,1,1},  '{3,0,0,1,0},  '{4,0,1,15,1}, '{4,0,1,15,0},
                '{4,0,1,2,1},  '{4,0,1,13,0}, '{4,0,1,0,1},  '{4,0,1,1,0},  '{5,0,1,4,1},
                '{5,0,1,5,0},  '{5,1,1,3,0},  '{5,0,1,6,0},  '{5,1,1,14,0}, '{6,0,1,8,1},
                '{6,0,1,9,0},  '{6,0,1,10,1}, '{6,0,1,11,0}, '{6,0,1,12,1}, '{6,0,1,16,0}};
        start_wburst = 1'b0;
        wr_en        = 1'b0;
        cseq_wr_en   = 1'b0;
        pre_waddr    = '0;
        waddr        = '0;
        wdata        = '0;
        cseq_waddr   = '0;
        cseq_wdata   = '0;
        repeat (5) @(posedge rst);
        mclk <= 1'b0;
        err_before = errors;
        repeat (20) @(posedge rst); // idle, monitor flags any strobe
        assert (!busy)
            else begin
                $display("MISMATCH busy exp 0x0 got 0x%h", busy);
                errors++;
            end
        $display("test 1 %s", errors == err_before ? "ok" : "FAILED");
        n_tests = 1;
        for (int i = 0; i < NUM; i++) begin
            if (i == 0 || tbl[i].test != tbl[i-1].test) begin
                err_before   = errors;
                busy_seen    = 1'b0;
                back_to_back = 0;
            end
            a = make_addr(tbl[i].win, tbl[i].idx);
            d = rand_bits(32);
            if (tbl[i].seq) begin
                offer_seq(a, d);
            end else begin
                if (i == 0 || !tbl[i-1].more || tbl[i-1].seq) announce(a);
                wr_en <= 1'b1;
                waddr <= a;
                wdata <= d;
                if (tbl[i].win) begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                    exp_seq.push_back(1'b0);
                    exp_cyc.push_back(0);
                end
                @(posedge rst);
                if (!tbl[i].more) wr_en <= 1'b0;
            end
            if (i == NUM - 1 || tbl[i+1].test != tbl[i].test) begin
                drain();
                if (tbl[i].test == 4) begin
                    assert (back_to_back != 0) // burst of two single-cycle commands
                        else begin
                            $display("no strobe right after a single-cycle command");
                            errors++;
                        end
                end
                if (tbl[i].test == 6) begin
                    assert (busy_seen)
                        else begin
                            $display("busy never rose while the buffer filled");
                            errors++;
                        end
                    assert (!busy)
                        else begin
                            $display("MISMATCH busy exp 0x0 got 0x%h", busy);
                            errors++;
                        end
                end
                $display("test %0d %s", tbl[i].test, errors == err_before ? "ok" : "FAILED");
                n_tests++;
            end
        end
        $display("tests %0d, errors %0d", n_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("timeout: simulation ran too long");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: tests/cmd_mux_props.sv
`timescale 1ns/1ps

module cmd_mux_props (
    input logic                  rst,        // clock
    input logic                  mclk,       // async reset, active high
    input logic                  ad_stb,
    input logic                  cseq_ackn,
    input logic                  held,       // sequencer command waiting
    input cmd_mux_pkg::cmd_len_t seq_length  // valid in the strobe cycle
);

    logic [3:0] hold; // cycles left in which no strobe may appear

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            hold <= '0;
        end else if (ad_stb) begin
            hold <= (seq_length >= 4'd2 && seq_length <= 4'd6) ? seq_length - 4'd1 : 4'd0;
        end else if (hold != '0) begin
            hold <= hold - 4'd1;
        end
    end

    a_spacing: assert property (@(posedge rst) disable iff (mclk) (hold != '0) |-> !ad_stb)
        else $error("strobe inside the spacing of a multi-cycle command");

    // a new accept with a command still held means the held one leaves now
    a_ackn: assert property (@(posedge rst) disable iff (mclk) cseq_ackn && held |=> ad_stb)
        else $error("cseq_ackn while the held command could not leave");

    a_reset: assert property (@(posedge rst) mclk |-> !ad_stb)
        else $error("ad_stb high during reset");

endmodule

bind cmd_serializer cmd_mux_props u_props (
    .rst        (rst),
    .mclk       (mclk),
    .ad_stb     (ad_stb),
    .cseq_ackn  (cseq_ackn),
    .held       (cmdseq_full_r),
    .seq_length (seq_length)
);

// File: hw/cmd_mux.sv
`timescale 1ns/1ps

module cmd_mux (
    input  logic               rst,          // clock
    input  logic               mclk,         // async reset, active high
    // bus write port
    input  logic               start_wburst, // burst announce
    input  cmd_mux_pkg::addr_t pre_waddr,    // burst address, valid with start_wburst
    input  cmd_mux_pkg::addr_t waddr,        // write address
    input  cmd_mux_pkg::data_t wdata,        // write data
    input  logic               wr_en,        // write strobe
    output logic               busy,         // no new burst while high
    // frame sequencer port
    input  cmd_mux_pkg::addr_t cseq_waddr,
    input  cmd_mux_pkg::data_t cseq_wdata,
    input  logic               cseq_wr_en,
    output logic               cseq_ackn,    // combinational accept
    // slave command bus
    output cmd_mux_pkg::addr_t par_waddr,
    output cmd_mux_pkg::data_t par_data,
    output logic [7:0]         byte_ad,
    output logic               ad_stb
);

    logic                    push;
    cmd_mux_pkg::fifo_word_t push_word;
    logic                    pop;
    cmd_mux_pkg::fifo_word_t pop_word;
    logic                    nempty;
    logic                    half_empty;

    cmd_window u_window (
        .rst          (rst),
        .mclk         (mclk),
        .start_wburst (start_wburst),
        .pre_waddr    (pre_waddr),
        .waddr        (waddr),
        .wdata        (wdata),
        .wr_en        (wr_en),
        .half_empty   (half_empty), // fill flag back from the buffer
        .busy         (busy),
        .push         (push),
        .push_word    (push_word)
    );

    cmd_buffer u_buffer (
        .rst        (rst),
        .mclk       (mclk),
        .push       (push),
        .push_word  (push_word),
        .pop        (pop),
        .pop_word   (pop_word),
        .nempty     (nempty),
        .half_empty (half_empty)
    );

    cmd_serializer u_serializer (
        .rst        (rst),
        .mclk       (mclk),
        .nempty     (nempty),
        .pop_word   (pop_word),
        .pop        (pop),        // same-cycle consume of the head
        .cseq_waddr (cseq_waddr),
        .cseq_wdata (cseq_wdata),
        .cseq_wr_en (cseq_wr_en),
        .cseq_ackn  (cseq_ackn),
        .par_waddr  (par_waddr),
        .par_data   (par_data),
        .byte_ad    (byte_ad),
        .ad_stb     (ad_stb)
    );

endmodule

// File: hw/cmd_serializer.sv
`timescale 1ns/1ps
`include "cmd_mux_params.svh"

module cmd_serializer (
    input  logic                    rst,        // clock
    input  logic                    mclk,       // async reset, active high
    input  logic                    nempty,     // buffer has a word
    input  cmd_mux_pkg::fifo_word_t pop_word,   // buffer head
    output logic                    pop,        // buffer head used this cycle
    input  cmd_mux_pkg::addr_t      cseq_waddr, // sequencer address, with cseq_wr_en
    input  cmd_mux_pkg::data_t      cseq_wdata, // sequencer data, with cseq_wr_en
    input  logic                    cseq_wr_en, // sequencer offers a command
    output logic                    cseq_ackn,  // sequencer command taken
    output cmd_mux_pkg::addr_t      par_waddr,  // parallel address, valid with ad_stb
    output cmd_mux_pkg::data_t      par_data,   // parallel data, valid with ad_stb
    output logic [7:0]              byte_ad,    // AL, AH, D0..D3 then zero
    output logic                    ad_stb      // command strobe
);

    localparam int PAD_BITS = 16 - $bits(cmd_mux_pkg::addr_t); // address padded to two bytes

    cmd_mux_pkg::addr_t   fifo_addr;
    cmd_mux_pkg::data_t   fifo_data;
    cmd_mux_pkg::addr_t   cseq_waddr_r;   // held sequencer command
    cmd_mux_pkg::data_t   cseq_wdata_r;
    logic                 cmdseq_full_r;  // held command waiting
    logic [47:0]          par_ad;         // output register, shifts a byte per cycle
    logic                 ad_stb_r;
    cmd_mux_pkg::cmd_len_t seq_length;    // decoded length of the command on the outputs
    logic [4:0]           seq_length_idx;
    logic [4:0]           seq_busy_r;     // pacing shift register
    logic                 ss;             // single-cycle command
    logic                 can_start_w;
    logic                 start_w;

    assign {fifo_addr, fifo_data} = pop_word;

    // length lookup, only meaningful in the strobe cycle
    assign seq_length_idx = par_ad[`CMD_LEN_LOW_BIT +: 5];

    always_comb begin
        case (seq_length_idx)
            5'd0:                       seq_length = 4'd2;
            5'd1:                       seq_length = 4'd4;
            5'd2, 5'd3:                 seq_length = 4'd3;
            5'd4, 5'd5:                 seq_length = 4'd6;
            5'd6, 5'd7:                 seq_length = 4'd4;
            5'd8, 5'd9, 5'd10:          seq_length = 4'd6;
            5'd11, 5'd12:               seq_length = 4'd6;
            5'd13:                      seq_length = 4'd5;
            5'd14:                      seq_length = 4'd6;
            5'd15:                      seq_length = 4'd9; // single-cycle
            default:                    seq_length = 4'd6; // upper half of the table
        endcase
    end

    assign ss = seq_length[3];

    // one bit per remaining busy cycle, loaded on the strobe
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            seq_busy_r <= '0;
        end else if (ad_stb_r) begin
            case (seq_length)
                4'd2:    seq_busy_r <= 5'h01;
                4'd3:    seq_busy_r <= 5'h03;
                4'd4:    seq_busy_r <= 5'h07;
                4'd5:    seq_busy_r <= 5'h0f;
                4'd6:    seq_busy_r <= 5'h1f;
                default: seq_busy_r <= 5'h00; // next strobe may follow at once
            endcase
        end else begin
            seq_busy_r <= {1'b0, seq_busy_r[4:1]};
        end
    end

    // in the strobe cycle only a single-cycle command lets the next one start
    // otherwise wait until one busy bit is left, the strobe register adds the last cycle
    assign can_start_w = ad_stb_r ? ss : !seq_busy_r[1];

    assign start_w = can_start_w && (cmdseq_full_r || nempty);
    assign pop     = can_start_w && !cmdseq_full_r && nempty; // held command wins

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            ad_stb_r <= 1'b0;
        end else begin
            ad_stb_r <= start_w;
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            par_ad <= '0;
        end else if (start_w) begin
            if (cmdseq_full_r) begin
                par_ad <= {cseq_wdata_r, {PAD_BITS{1'b0}}, cseq_waddr_r};
            end else begin
                par_ad <= {fifo_data, {PAD_BITS{1'b0}}, fifo_addr};
            end
        end else begin
            par_ad <= {8'h00, par_ad[47:8]}; // next byte down, zero fill
        end
    end

    // free slot, or the held command leaves in this cycle
    assign cseq_ackn = cseq_wr_en && (!cmdseq_full_r || can_start_w);

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            cmdseq_full_r <= 1'b0;
        end else begin
            cmdseq_full_r <= cseq_ackn || (cmdseq_full_r && !can_start_w);
        end
    end

    always_ff @(posedge rst) begin
        if (cseq_ackn) begin
            cseq_waddr_r <= cseq_waddr;
            cseq_wdata_r <= cseq_wdata;
        end
    end

    assign par_waddr = par_ad[$bits(cmd_mux_pkg::addr_t)-1:0];
    assign par_data  = par_ad[47:16];
    assign byte_ad   = par_ad[7:0];
    assign ad_stb    = ad_stb_r;

endmodule

// File: hw/cmd_buffer.sv
`timescale 1ns/1ps
`include "cmd_mux_params.svh"

module cmd_buffer (
    input  logic                    rst,        // clock
    input  logic                    mclk,       // async reset, active high
    input  logic                    push,       // write push_word
    input  cmd_mux_pkg::fifo_word_t push_word,  // entry in
    input  logic                    pop,        // consume pop_word this cycle
    output cmd_mux_pkg::fifo_word_t pop_word,   // head entry, shown before pop
    output logic                    nempty,     // at least one entry
    output logic                    half_empty  // fewer than half the entries used
);

    localparam int PTR_W = $clog2(`CMD_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`CMD_FIFO_DEPTH + 1);

    cmd_mux_pkg::fifo_word_t mem [`CMD_FIFO_DEPTH]; // storage, no reset

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count; // entries in use
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`CMD_FIFO_DEPTH - 1)) begin
            return '0; // wrap
        end
        return ptr + 1'b1;
    endfunction

    assign full    = count == CNT_W'(`CMD_FIFO_DEPTH);
    assign do_pop  = pop && nempty;
    assign do_push = push && (!full || do_pop); // a full buffer still takes a word on pop

    always_ff @(posedge rst) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    assign pop_word   = mem[rd_ptr]; // fall-through head
    assign nempty     = count != '0;
    assign half_empty = count < CNT_W'(`CMD_FIFO_DEPTH / 2);

endmodule

// File: hw/cmd_window.sv
`timescale 1ns/1ps
`include "cmd_mux_params.svh"

module cmd_window (
    input  logic                rst,          // clock
    input  logic                mclk,         // async reset, active high
    input  logic                start_wburst, // burst announce, valid with pre_waddr
    input  cmd_mux_pkg::addr_t  pre_waddr,    // burst address, ahead of the writes
    input  cmd_mux_pkg::addr_t  waddr,        // write address, with wr_en
    input  cmd_mux_pkg::data_t  wdata,        // write data, with wr_en
    input  logic                wr_en,        // write strobe
    input  logic                half_empty,   // buffer fill below half
    output logic                busy,         // back-pressure to the bus
    output logic                push,         // buffer write
    output cmd_mux_pkg::fifo_word_t push_word // buffer entry
);

    logic selected;   // current burst targets the control window
    logic selected_w; // window decode of the announced burst
    logic busy_r;     // buffer past half full, registered

    // masked compare against the window base
    assign selected_w = ((pre_waddr ^ cmd_mux_pkg::addr_t'(`CMD_CTRL_ADDR))
                        & cmd_mux_pkg::addr_t'(`CMD_CTRL_MASK)) == '0;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            selected <= 1'b0;
        end else if (start_wburst) begin
            selected <= selected_w; // held for the whole burst
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            busy_r <= 1'b0;
        end else begin
            busy_r <= !half_empty;
        end
    end

    // a new burst uses its own decode, otherwise the held one
    // so busy follows start_wburst without a cycle of delay
    assign busy = busy_r && (start_wburst ? selected_w : selected);

    assign push      = wr_en && selected; // writes outside the window are dropped
    assign push_word = {waddr, wdata};

endmodule

// File: hw/cmd_mux_pkg.sv
`include "cmd_mux_params.svh"

package cmd_mux_pkg;

    // command address, same width on every source
    typedef logic [`CMD_ADDR_BITS-1:0] addr_t;

    // command payload
    typedef logic [31:0] data_t;

    // encoded command length from the address decode
    // 2..6 is a cycle count, bit 3 marks a single-cycle command
    typedef logic [3:0] cmd_len_t;

    // buffer entry, address in the upper bits and data below
    typedef logic [$bits(addr_t)+$bits(data_t)-1:0] fifo_word_t;

endpackage

// File: hw/cmd_mux_params.svh
`ifndef CMD_MUX_PARAMS_SVH
`define CMD_MUX_PARAMS_SVH

// command address width on both bus and sequencer side
`define CMD_ADDR_BITS 14

// control window, burst address is masked then compared to base
`define CMD_CTRL_ADDR 'h0000
`define CMD_CTRL_MASK 'h3800 // only the top three address bits select the window

// five address bits starting here select the command length
`define CMD_LEN_LOW_BIT 6

// bus-side buffer, power of two
`define CMD_FIFO_DEPTH 4

`endif
